//--- pipeCpu_macros.svh
//////////////////////////////
// Core-wide widths and instruction field sizes
// PC value after reset
//////////////////////////////
`ifndef PIPECPU_MACROS_SVH
`define PIPECPU_MACROS_SVH

// Datapath width shared by registers, ALU and data memory address
`define DATA_W 32

// Register file index width
`define REG_IDX_W 5

// I-type immediate occupies bits [16:0]
`define IMM_W 17

// J-type target occupies bits [26:0]
`define TARGET_W 27

// Word address bits presented to the instruction memory
`define IMEM_ADDR_W 12

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

//--- pipeCpuPkg.sv
//////////////////////////////
// Opcode and ALU encodings, instruction field view
// Stage payload structs and small decode helpers
//////////////////////////////
`default_nettype none
`include "pipeCpu_macros.svh"

package pipeCpuPkg;

    // Primary opcode in bits [31:27]
    typedef enum logic [4:0] {
        rType = 5'b00000,
        jump  = 5'b00001,
        bne   = 5'b00010,
        addi  = 5'b00101,
        sw    = 5'b00111,
        lw    = 5'b01000
    } opcode_e;

    // R-type function code in bits [6:2]
    typedef enum logic [4:0] {
        aluAdd = 5'b00000,
        aluSub = 5'b00001,
        aluAnd = 5'b00010,
        aluOr  = 5'b00011,
        aluSll = 5'b00100,
        aluSra = 5'b00101
    } aluOp_e;

    // R-type layout
    // Immediate and target overlay the low bits
    typedef struct packed {
        opcode_e               opcode;
        logic [`REG_IDX_W-1:0] rd;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rt;
        logic [4:0]            shamt;
        aluOp_e                aluOp;
        logic [1:0]            pad;
    } instr_t;

    typedef struct packed {
        instr_t             instr;
        logic [`DATA_W-1:0] pcPlus1;
    } fetchDecode_t;

    // rtData carries $rd for bne and sw
    typedef struct packed {
        instr_t             instr;
        logic [`DATA_W-1:0] pcPlus1;
        logic [`DATA_W-1:0] rsData;
        logic [`DATA_W-1:0] rtData;
    } decodeExec_t;

    typedef struct packed {
        instr_t             instr;
        logic [`DATA_W-1:0] aluResult;
        logic [`DATA_W-1:0] storeData;
    } execMem_t;

    typedef struct packed {
        instr_t             instr;
        logic [`DATA_W-1:0] aluResult;
        logic [`DATA_W-1:0] memData;
    } memWb_t;

    typedef struct packed {
        logic               taken;
        logic [`DATA_W-1:0] target;
    } redirect_t;

    // bne and sw read $rd through port B instead of $rt
    function automatic logic readsRdOnB(opcode_e op);
        return (op == bne) || (op == sw);
    endfunction

    // True when the instruction leaves a value in a nonzero register
    function automatic logic writesReg(instr_t i);
        return (i.opcode inside {rType, addi, lw}) && (i.rd != '0);
    endfunction

endpackage

`default_nettype wire

//--- fetchStage.sv
//////////////////////////////
// Fetch stage
// PC, next-PC select and fetch/decode register
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "pipeCpu_macros.svh"

module fetchStage (
    input  logic                     clock,
    input  logic                     rst,
    input  logic                     stall,
    input  pipeCpuPkg::redirect_t    redirect,
    output logic [`IMEM_ADDR_W-1:0]  imemAddress,
    input  logic [`DATA_W-1:0]       imemData,
    output pipeCpuPkg::fetchDecode_t fetchOut
);
    import pipeCpuPkg::*;

    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] pcPlus1;
    logic [`DATA_W-1:0] pcNext;
    instr_t             fdInstr;
    logic [`DATA_W-1:0] fdPcPlus1;

    //////////////////////////////
    // Program counter
    //////////////////////////////

    assign pcPlus1 = pc + 32'd1;

    // Taken branch or jump from execute wins over sequential flow
    assign pcNext = redirect.taken ? redirect.target : pcPlus1;

    // Instruction memory is word addressed and read in the same cycle
    assign imemAddress = pc[`IMEM_ADDR_W-1:0];

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (!stall) begin
            pc <= pcNext;
        end
    end

    //////////////////////////////
    // Fetch/decode register
    //////////////////////////////

    // Word fetched under a redirect is on the wrong path
    always_ff @(posedge clock) begin
        if (rst) begin
            fdInstr <= '0;
        end else if (redirect.taken) begin
            fdInstr <= '0;
        end else if (!stall) begin
            fdInstr <= instr_t'(imemData);
        end
    end

    // Link value travels with the word for branch targets
    always_ff @(posedge clock) begin
        if (!stall) begin
            fdPcPlus1 <= pcPlus1;
        end
    end

    assign fetchOut = '{instr: fdInstr, pcPlus1: fdPcPlus1};

    // Load-use hold never meets a redirect and freezes the PC for that cycle
    pcHoldOnStall: assert property (@(posedge clock) disable iff (rst)
        stall |-> !redirect.taken ##1 $stable(pc));

endmodule

`default_nettype wire

//--- decodeStage.sv
//////////////////////////////
// Decode stage
// Register read addressing, load-use detect
// and the decode/execute register
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "pipeCpu_macros.svh"

module decodeStage (
    input  logic                      clock,
    input  logic                      rst,
    input  pipeCpuPkg::fetchDecode_t  fetchIn,
    input  pipeCpuPkg::redirect_t     redirect,
    output logic [`REG_IDX_W-1:0]     regReadIndexA,
    output logic [`REG_IDX_W-1:0]     regReadIndexB,
    input  logic [`DATA_W-1:0]        regReadDataA,
    input  logic [`DATA_W-1:0]        regReadDataB,
    output logic                      stall,
    output pipeCpuPkg::decodeExec_t   decodeOut
);
    import pipeCpuPkg::*;

    instr_t             instr;
    instr_t             dxInstr;
    logic [`DATA_W-1:0] dxPcPlus1;
    logic [`DATA_W-1:0] dxRsData;
    logic [`DATA_W-1:0] dxRtData;
    logic               rsHit;
    logic               rtHit;
    logic               bubble;

    assign instr = fetchIn.instr;

    //////////////////////////////
    // Register file addressing
    //////////////////////////////

    // Port A always reads $rs
    assign regReadIndexA = instr.rs;

    // Port B reads $rd for bne and sw
    // and $rt for everything else
    assign regReadIndexB = readsRdOnB(instr.opcode) ? instr.rd : instr.rt;

    //////////////////////////////
    // Load-use hazard
    //////////////////////////////

    // Older lw sits in the decode/execute register this cycle
    assign rsHit = (instr.rs == dxInstr.rd);

    // Port B match covers $rt and the $rd source of bne
    // sw store data is repaired later by forwarding in memory
    assign rtHit = (regReadIndexB == dxInstr.rd) && (instr.opcode != sw);

    assign stall = (dxInstr.opcode == lw) && (rsHit || rtHit);

    // Flush on redirect and bubble on load-use
    assign bubble = redirect.taken || stall;

    //////////////////////////////
    // Decode/execute register
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            dxInstr <= '0;
        end else if (bubble) begin
            dxInstr <= '0;
        end else begin
            dxInstr <= instr;
        end
    end

    // Operands and link value follow the instruction unconditionally
    always_ff @(posedge clock) begin
        dxPcPlus1 <= fetchIn.pcPlus1;
        dxRsData  <= regReadDataA;
        dxRtData  <= regReadDataB;
    end

    assign decodeOut = '{
        instr:   dxInstr,
        pcPlus1: dxPcPlus1,
        rsData:  dxRsData,
        rtData:  dxRtData
    };

endmodule

`default_nettype wire

//--- executeStage.sv
//////////////////////////////
// Execute stage
// Operand forwarding, ALU, branch and jump resolve
// and the execute/memory register
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "pipeCpu_macros.svh"

module executeStage (
    input  logic                    clock,
    input  logic                    rst,
    input  pipeCpuPkg::decodeExec_t decodeIn,
    input  pipeCpuPkg::execMem_t    memIn,
    input  pipeCpuPkg::memWb_t      wbIn,
    input  logic [`DATA_W-1:0]      wbData,
    output pipeCpuPkg::redirect_t   redirect,
    output pipeCpuPkg::execMem_t    execOut
);
    import pipeCpuPkg::*;

    instr_t                instr;
    logic [`DATA_W-1:0]    instrBits;
    logic [`REG_IDX_W-1:0] srcB;
    logic                  fwdMemA;
    logic                  fwdMemB;
    logic                  fwdWbA;
    logic                  fwdWbB;
    logic [`DATA_W-1:0]    opA;
    logic [`DATA_W-1:0]    opB;
    logic [`DATA_W-1:0]    immExt;
    logic [`DATA_W-1:0]    targetExt;
    logic                  useImm;
    aluOp_e                aluSel;
    logic [`DATA_W-1:0]    aluB;
    logic [`DATA_W-1:0]    aluResult;
    instr_t                xmInstr;
    logic [`DATA_W-1:0]    xmAluResult;
    logic [`DATA_W-1:0]    xmStoreData;

    assign instr     = decodeIn.instr;
    assign instrBits = decodeIn.instr;

    // Same port B choice as decode
    assign srcB = readsRdOnB(instr.opcode) ? instr.rd : instr.rt;

    //////////////////////////////
    // Forwarding
    //////////////////////////////

    // writesReg already rules out $r0 and bne/sw/j producers
    assign fwdMemA = writesReg(memIn.instr) && (memIn.instr.rd == instr.rs);
    assign fwdMemB = writesReg(memIn.instr) && (memIn.instr.rd == srcB);
    assign fwdWbA  = writesReg(wbIn.instr) && (wbIn.instr.rd == instr.rs);
    assign fwdWbB  = writesReg(wbIn.instr) && (wbIn.instr.rd == srcB);

    // Younger producer in memory takes priority
    assign opA = fwdMemA ? memIn.aluResult :
                 fwdWbA  ? wbData : decodeIn.rsData;
    assign opB = fwdMemB ? memIn.aluResult :
                 fwdWbB  ? wbData : decodeIn.rtData;

    //////////////////////////////
    // ALU
    //////////////////////////////

    assign immExt    = {{(`DATA_W - `IMM_W){instrBits[`IMM_W-1]}}, instrBits[`IMM_W-1:0]};
    assign targetExt = {{(`DATA_W - `TARGET_W){instrBits[`TARGET_W-1]}},
                        instrBits[`TARGET_W-1:0]};

    // addi, lw and sw add the immediate to $rs
    assign useImm = instr.opcode inside {addi, lw, sw};
    assign aluB   = useImm ? immExt : opB;

    // Only R-type looks at the function field
    assign aluSel = (instr.opcode == rType) ? instr.aluOp : aluAdd;

    always_comb begin
        case (aluSel)
            aluAdd:  aluResult = opA + aluB;
            aluSub:  aluResult = opA - aluB;
            aluAnd:  aluResult = opA & aluB;
            aluOr:   aluResult = opA | aluB;
            aluSll:  aluResult = opA << instr.shamt;
            aluSra:  aluResult = $signed(opA) >>> instr.shamt;
            default: aluResult = '0;
        endcase
    end

    //////////////////////////////
    // Branch and jump resolve
    //////////////////////////////

    // bne compares $rd on port B with $rs
    always_comb begin
        redirect.taken  = 1'b0;
        redirect.target = decodeIn.pcPlus1 + immExt;
        if (instr.opcode == jump) begin
            redirect.taken  = 1'b1;
            redirect.target = targetExt;
        end else if ((instr.opcode == bne) && (opA != opB)) begin
            redirect.taken = 1'b1;
        end
    end

    //////////////////////////////
    // Execute/memory register
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            xmInstr <= '0;
        end else begin
            xmInstr <= instr;
        end
    end

    // Store data keeps the forwarded $rd value
    always_ff @(posedge clock) begin
        xmAluResult <= aluResult;
        xmStoreData <= opB;
    end

    assign execOut = '{instr: xmInstr, aluResult: xmAluResult, storeData: xmStoreData};

    // Anything other than a bubble must carry a known opcode
    opcodeKnown: assert property (@(posedge clock) disable iff (rst)
        (instr != '0) |-> (instr.opcode inside {rType, jump, bne, addi, sw, lw}));

endmodule

`default_nettype wire

//--- memWriteback.sv
//////////////////////////////
// Memory and writeback stages
// Data memory access, store forwarding,
// memory/writeback register and result select
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "pipeCpu_macros.svh"

module memWriteback (
    input  logic                  clock,
    input  logic                  rst,
    input  pipeCpuPkg::execMem_t  execIn,
    output logic [`DATA_W-1:0]    dmemAddress,
    output logic [`DATA_W-1:0]    dmemWriteData,
    output logic                  dmemWriteEnable,
    input  logic [`DATA_W-1:0]    dmemReadData,
    output pipeCpuPkg::memWb_t    wbOut,
    output logic                  regWriteEnable,
    output logic [`REG_IDX_W-1:0] regWriteIndex,
    output logic [`DATA_W-1:0]    regWriteData
);
    import pipeCpuPkg::*;

    logic               storeFwd;
    instr_t             mwInstr;
    logic [`DATA_W-1:0] mwAluResult;
    logic [`DATA_W-1:0] mwMemData;

    //////////////////////////////
    // Data memory
    //////////////////////////////

    assign dmemAddress     = execIn.aluResult;
    assign dmemWriteEnable = (execIn.instr.opcode == sw);

    // lw directly ahead of a sw on the same register
    // lands here since decode does not stall sw on its data
    assign storeFwd = (execIn.instr.opcode == sw) && writesReg(mwInstr) &&
                      (execIn.instr.rd == mwInstr.rd);

    assign dmemWriteData = storeFwd ? regWriteData : execIn.storeData;

    //////////////////////////////
    // Memory/writeback register
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            mwInstr <= '0;
        end else begin
            mwInstr <= execIn.instr;
        end
    end

    always_ff @(posedge clock) begin
        mwAluResult <= execIn.aluResult;
        mwMemData   <= dmemReadData;
    end

    assign wbOut = '{instr: mwInstr, aluResult: mwAluResult, memData: mwMemData};

    // Writeback select
    assign regWriteEnable = writesReg(mwInstr);
    assign regWriteIndex  = mwInstr.rd;
    assign regWriteData   = (mwInstr.opcode == lw) ? mwMemData : mwAluResult;

    // Memory writes only come from a store and carry a known address and word
    storeOnly: assert property (@(posedge clock) disable iff (rst)
        dmemWriteEnable |-> (execIn.instr.opcode == sw) &&
            !$isunknown({dmemAddress, dmemWriteData}));

endmodule

`default_nettype wire

//--- pipeCpu.sv
//////////////////////////////
// Five-stage core top level
// Memories and register file live outside
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "pipeCpu_macros.svh"

module pipeCpu (
    input  logic                    clock,
    input  logic                    rst,

    // Instruction memory
    output logic [`IMEM_ADDR_W-1:0] imemAddress,
    input  logic [`DATA_W-1:0]      imemData,

    // Data memory
    output logic [`DATA_W-1:0]      dmemAddress,
    output logic [`DATA_W-1:0]      dmemWriteData,
    output logic                    dmemWriteEnable,
    input  logic [`DATA_W-1:0]      dmemReadData,

    // Register file
    output logic                    regWriteEnable,
    output logic [`REG_IDX_W-1:0]   regWriteIndex,
    output logic [`DATA_W-1:0]      regWriteData,
    output logic [`REG_IDX_W-1:0]   regReadIndexA,
    output logic [`REG_IDX_W-1:0]   regReadIndexB,
    input  logic [`DATA_W-1:0]      regReadDataA,
    input  logic [`DATA_W-1:0]      regReadDataB
);
    import pipeCpuPkg::*;

    // Stage payloads
    fetchDecode_t fdBus;
    decodeExec_t  dxBus;
    execMem_t     xmBus;
    memWb_t       mwBus;

    // Control back toward the front end
    redirect_t    redirect;
    logic         stall;

    fetchStage fetchStage_i (
        .clock       (clock),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .imemAddress (imemAddress),
        .imemData    (imemData),
        .fetchOut    (fdBus)
    );

    decodeStage decodeStage_i (
        .clock         (clock),
        .rst           (rst),
        .fetchIn       (fdBus),
        .redirect      (redirect),
        .regReadIndexA (regReadIndexA),
        .regReadIndexB (regReadIndexB),
        .regReadDataA  (regReadDataA),
        .regReadDataB  (regReadDataB),
        .stall         (stall),
        .decodeOut     (dxBus)
    );

    // Writeback value loops back for forwarding
    executeStage executeStage_i (
        .clock    (clock),
        .rst      (rst),
        .decodeIn (dxBus),
        .memIn    (xmBus),
        .wbIn     (mwBus),
        .wbData   (regWriteData),
        .redirect (redirect),
        .execOut  (xmBus)
    );

    memWriteback memWriteback_i (
        .clock           (clock),
        .rst             (rst),
        .execIn          (xmBus),
        .dmemAddress     (dmemAddress),
        .dmemWriteData   (dmemWriteData),
        .dmemWriteEnable (dmemWriteEnable),
        .dmemReadData    (dmemReadData),
        .wbOut           (mwBus),
        .regWriteEnable  (regWriteEnable),
        .regWriteIndex   (regWriteIndex),
        .regWriteData    (regWriteData)
    );

endmodule

`default_nettype wire

//--- pipeCpuTbModels.sv
//////////////////////////////
// Testbench instruction memory, data memory
// and register file models
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "pipeCpu_macros.svh"

module pipeCpuTbModels (
    input  logic                    clock,
    input  logic [`IMEM_ADDR_W-1:0] imemAddress,
    output logic [`DATA_W-1:0]      imemData,
    input  logic [`DATA_W-1:0]      dmemAddress,
    input  logic [`DATA_W-1:0]      dmemWriteData,
    input  logic                    dmemWriteEnable,
    output logic [`DATA_W-1:0]      dmemReadData,
    input  logic                    regWriteEnable,
    input  logic [`REG_IDX_W-1:0]   regWriteIndex,
    input  logic [`DATA_W-1:0]      regWriteData,
    input  logic [`REG_IDX_W-1:0]   regReadIndexA,
    input  logic [`REG_IDX_W-1:0]   regReadIndexB,
    output logic [`DATA_W-1:0]      regReadDataA,
    output logic [`DATA_W-1:0]      regReadDataB
);
    localparam int IMEM_WORDS = 1 << `IMEM_ADDR_W;
    localparam int DMEM_WORDS = 256;

    logic [`DATA_W-1:0] imem [0:IMEM_WORDS-1];
    logic [`DATA_W-1:0] dmem [0:DMEM_WORDS-1];
    logic [`DATA_W-1:0] regs [0:31];

    // Both memories answer in the same cycle
    assign imemData     = imem[imemAddress];
    assign dmemReadData = dmem[dmemAddress[7:0]];

    // Store lands at the rising edge
    always @(posedge clock) begin
        if (dmemWriteEnable) begin
            dmem[dmemAddress[7:0]] <= dmemWriteData;
        end
    end

    // Falling-edge write lets decode see the value in the same cycle
    always @(negedge clock) begin
        if (regWriteEnable && (regWriteIndex != '0)) begin
            regs[regWriteIndex] <= regWriteData;
        end
    end

    // Register 0 reads as zero
    assign regReadDataA = (regReadIndexA == '0) ? '0 : regs[regReadIndexA];
    assign regReadDataB = (regReadIndexB == '0) ? '0 : regs[regReadIndexB];

    // Empty instruction memory is all no-ops
    task automatic clearAll();
        int i;
        for (i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = '0;
        end
        for (i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = '0;
        end
        for (i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
    endtask

    task automatic loadWord(input int addr, input logic [`DATA_W-1:0] word);
        imem[addr] = word;
    endtask

endmodule

`default_nettype wire

//--- pipeCpuTb.sv
//////////////////////////////
// Directed and random program tests for the core
// Sequential reference model, checker and watchdog
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "pipeCpu_macros.svh"

module pipeCpuTb;
    import pipeCpuPkg::*;

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 4;
    localparam int SLACK        = 10;
    localparam int MAX_PROG     = 24;
    localparam int NUM_TESTS    = 6;
    localparam int DMEM_WORDS   = 256;
    // Every test fits reset plus the largest program plus drain
    localparam int BUDGET_CYCLES = NUM_TESTS * (RESET_CYCLES + MAX_PROG + SLACK);

    logic                    clock;
    logic                    rst;
    logic [`IMEM_ADDR_W-1:0] imemAddress;
    logic [`DATA_W-1:0]      imemData;
    logic [`DATA_W-1:0]      dmemAddress;
    logic [`DATA_W-1:0]      dmemWriteData;
    logic                    dmemWriteEnable;
    logic [`DATA_W-1:0]      dmemReadData;
    logic                    regWriteEnable;
    logic [`REG_IDX_W-1:0]   regWriteIndex;
    logic [`DATA_W-1:0]      regWriteData;
    logic [`REG_IDX_W-1:0]   regReadIndexA;
    logic [`REG_IDX_W-1:0]   regReadIndexB;
    logic [`DATA_W-1:0]      regReadDataA;
    logic [`DATA_W-1:0]      regReadDataB;

    int          errors;
    int          checks;
    logic [31:0] rngState;
    logic [31:0] prog [$];
    logic [31:0] refRegs [0:31];
    logic [31:0] refMem [0:DMEM_WORDS-1];

    pipeCpu pipeCpu_i (.*);

    pipeCpuTbModels models_i (.*);

    always #(PERIOD / 2) clock = ~clock;

    //////////////////////////////
    // Instruction encoding
    //////////////////////////////

    function automatic logic [31:0] rTypeWord(aluOp_e op, int rd, int rs, int rt, int sh);
        return {rType, 5'(rd), 5'(rs), 5'(rt), 5'(sh), op, 2'b00};
    endfunction

    function automatic logic [31:0] immWord(opcode_e op, int rd, int rs, int imm);
        return {op, 5'(rd), 5'(rs), 17'(imm)};
    endfunction

    function automatic logic [31:0] jumpWord(int target);
        return {jump, 27'(target)};
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    //////////////////////////////
    // Sequential reference model
    //////////////////////////////

    function automatic logic [31:0] aluResultOf(logic [4:0] op, logic [31:0] a, logic [31:0] b,
                                                logic [4:0] sh);
        case (op)
            aluAdd:  return a + b;
            aluSub:  return a - b;
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluSll:  return a << sh;
            aluSra:  return $signed(a) >>> sh;
            default: return 32'h0;
        endcase
    endfunction

    task automatic writeExpected(logic [4:0] rd, logic [31:0] value);
        if (rd != 5'd0) begin
            refRegs[rd] = value;
        end
    endtask

    // Steps one instruction at a time until the PC leaves the program
    task automatic evalReference();
        int          pc;
        int          steps;
        int          i;
        logic [31:0] word;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] rdVal;
        logic [31:0] imm;
        logic [4:0]  rd;
        for (i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        for (i = 0; i < DMEM_WORDS; i++) begin
            refMem[i] = '0;
        end
        pc = 0;
        steps = 0;
        while ((pc >= 0) && (pc < prog.size()) && (steps < 4 * MAX_PROG)) begin
            word  = prog[pc];
            rd    = word[26:22];
            rsVal = refRegs[word[21:17]];
            rtVal = refRegs[word[16:12]];
            rdVal = refRegs[rd];
            imm   = {{15{word[16]}}, word[16:0]};
            pc    = pc + 1;
            steps = steps + 1;
            case (word[31:27])
                rType:   writeExpected(rd, aluResultOf(word[6:2], rsVal, rtVal, word[11:7]));
                addi:    writeExpected(rd, rsVal + imm);
                lw:      writeExpected(rd, refMem[8'(rsVal + imm)]);
                sw:      refMem[8'(rsVal + imm)] = rdVal;
                // Branch offset counts from the next word
                bne:     if (rdVal != rsVal) pc = pc + int'($signed(imm));
                jump:    pc = int'($signed({{5{word[26]}}, word[26:0]}));
                default: ;
            endcase
        end
    endtask

    //////////////////////////////
    // Checking and program runs
    //////////////////////////////

    task automatic checkValue(string testName, string what, logic [31:0] expected,
                              logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic runProgram(string testName);
        int i;
        if (prog.size() > MAX_PROG) begin
            errors++;
            $display("Program of test %s has %0d words, more than the %0d the watchdog allows",
                     testName, prog.size(), MAX_PROG);
        end
        rst = 1'b1;
        @(negedge clock);
        // Pipeline is already in reset here
        models_i.clearAll();
        for (i = 0; i < prog.size(); i++) begin
            models_i.loadWord(i, prog[i]);
        end
        repeat (RESET_CYCLES - 1) @(negedge clock);
        rst = 1'b0;
        repeat (prog.size() + SLACK) @(negedge clock);
        evalReference();
        for (i = 1; i < 32; i++) begin
            checkValue(testName, $sformatf("r%0d", i), refRegs[i], models_i.regs[i]);
        end
        for (i = 0; i < DMEM_WORDS; i++) begin
            checkValue(testName, $sformatf("mem[%0d]", i), refMem[i], models_i.dmem[i]);
        end
    endtask

    // Back-to-back dependences hit memory and writeback forwarding
    task automatic arithChainTest();
        prog.delete();
        prog.push_back(immWord(addi, 1, 0, 5));
        prog.push_back(immWord(addi, 2, 1, -3));
        prog.push_back(rTypeWord(aluAdd, 3, 2, 1, 0));
        prog.push_back(rTypeWord(aluSub, 4, 3, 2, 0));
        prog.push_back(rTypeWord(aluAnd, 5, 4, 3, 0));
        prog.push_back(rTypeWord(aluOr, 6, 5, 2, 0));
        prog.push_back(rTypeWord(aluSll, 7, 6, 0, 4));
        prog.push_back(rTypeWord(aluSra, 8, 7, 0, 2));
        prog.push_back(immWord(addi, 9, 8, -100));
        prog.push_back(rTypeWord(aluSra, 10, 9, 0, 3));
        runProgram("arithChain");
    endtask

    // Store forwarding, load-use stalls and memory contents
    task automatic storeLoadTest();
        prog.delete();
        prog.push_back(immWord(addi, 1, 0, 20));
        prog.push_back(immWord(addi, 2, 0, 1234));
        prog.push_back(rTypeWord(aluAdd, 3, 2, 2, 0));
        prog.push_back(immWord(sw, 3, 1, 4));
        prog.push_back(immWord(lw, 4, 1, 4));
        prog.push_back(rTypeWord(aluAdd, 5, 4, 1, 0));
        prog.push_back(immWord(sw, 5, 1, 0));
        prog.push_back(immWord(lw, 6, 1, 0));
        // Store data straight from the load ahead of it
        prog.push_back(immWord(sw, 6, 1, 8));
        prog.push_back(immWord(lw, 7, 1, 8));
        prog.push_back(immWord(addi, 8, 7, 1));
        runProgram("storeLoad");
    endtask

    // r5 and r6 sit in the shadow of the taken bne
    task automatic branchTest();
        prog.delete();
        prog.push_back(immWord(addi, 1, 0, 7));
        prog.push_back(immWord(addi, 2, 0, 7));
        prog.push_back(immWord(bne, 1, 2, 2));
        prog.push_back(immWord(addi, 3, 0, 11));
        prog.push_back(immWord(addi, 4, 0, 3));
        prog.push_back(immWord(bne, 4, 1, 2));
        prog.push_back(immWord(addi, 5, 0, 99));
        prog.push_back(immWord(addi, 6, 0, 98));
        prog.push_back(immWord(addi, 7, 0, 55));
        prog.push_back(immWord(addi, 8, 7, 1));
        runProgram("branch");
    endtask

    // Words skipped by either jump must stay unwritten
    task automatic jumpTest();
        prog.delete();
        prog.push_back(immWord(addi, 1, 0, 1));
        prog.push_back(jumpWord(5));
        prog.push_back(immWord(addi, 2, 0, 2));
        prog.push_back(immWord(addi, 3, 0, 3));
        prog.push_back(immWord(addi, 4, 0, 4));
        prog.push_back(immWord(addi, 5, 1, 5));
        prog.push_back(jumpWord(9));
        prog.push_back(immWord(addi, 6, 0, 6));
        prog.push_back(immWord(addi, 7, 0, 7));
        prog.push_back(rTypeWord(aluAdd, 8, 5, 1, 0));
        runProgram("jump");
    endtask

    // Seeds r1..r7 and then mixes random ALU work over r0..r7
    task automatic randomTest(string testName);
        int i;
        int kind;
        int rd;
        int rs;
        int rt;
        prog.delete();
        for (i = 1; i < 8; i++) begin
            prog.push_back(immWord(addi, i, 0, int'(nextRand())));
        end
        for (i = 0; i < MAX_PROG - 7; i++) begin
            kind = int'(nextRand() % 7);
            rd   = int'(nextRand() % 8);
            rs   = int'(nextRand() % 8);
            rt   = int'(nextRand() % 8);
            if (kind == 0) begin
                prog.push_back(immWord(addi, rd, rs, int'(nextRand())));
            end else begin
                prog.push_back(rTypeWord(aluOp_e'(kind - 1), rd, rs, rt,
                                         int'(nextRand() % 32)));
            end
        end
        runProgram(testName);
    endtask

    initial begin
        clock    = 1'b0;
        rst      = 1'b1;
        errors   = 0;
        checks   = 0;
        rngState = 32'hfa71_80aa;
        arithChainTest();
        storeLoadTest();
        branchTest();
        jumpTest();
        randomTest("random0");
        randomTest("random1");
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Twice the cycle budget of all tests
    initial begin
        #(2 * BUDGET_CYCLES * PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
pipeCpuPkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memWriteback.sv
pipeCpu.sv
pipeCpuTbModels.sv
pipeCpuTb.sv
